//--- hdl/sysCtrlPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths, types and command encodings of the system
// controller. RTL and testbench files import it with a wildcard.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package sysCtrlPkg;

    // bus widths
    localparam int dataW   = 8;          // uart byte and register data
    localparam int addrW   = 4;          // 16 entry register file
    localparam int aluFunW = 4;          // alu function code
    localparam int resultW = 2 * dataW;  // alu result of two bytes

    // payload types
    typedef logic [dataW-1:0]   dataByteT;
    typedef logic [addrW-1:0]   regAddrT;
    typedef logic [aluFunW-1:0] aluFunT;
    typedef logic [resultW-1:0] resultWordT;

    // first byte of each frame selects its kind
    localparam dataByteT cmdRfWrite       = 8'hAA;  // cmd, addr, data
    localparam dataByteT cmdRfRead        = 8'hBB;  // cmd, addr
    localparam dataByteT cmdAluOperands   = 8'hCC;  // cmd, opA, opB, fun
    localparam dataByteT cmdAluNoOperands = 8'hDD;  // cmd, fun

    // alu reads its operands from these two register slots
    localparam regAddrT operandAAddr = 4'd0;
    localparam regAddrT operandBAddr = 4'd1;

endpackage

//--- hdl/cmdDecoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Frame parser for the received byte stream. Issues register
// writes directly and hands reads and ALU runs to the execute
// stage, then sleeps until the result has been sent.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module cmdDecoder
    import sysCtrlPkg::*;
(
    input  logic     REF_CLK,
    input  logic     RST,
    input  dataByteT rxData,
    input  logic     rxDataValid,   // one cycle per byte
    input  logic     sendDone,      // last result byte is out
    output regAddrT  regAddr,
    output dataByteT regWrData,
    output logic     regWrEn,
    output aluFunT   aluFun,
    output logic     rdReq,
    output logic     aluReq
);

    typedef enum logic [2:0]
    {
        stIdle,
        stWrAddr,
        stWrData,
        stRdAddr,
        stOpA,
        stOpB,
        stFun,
        stWaitResult
    } stateT;

    stateT   state;
    stateT   nextState;
    logic    wrEnNext;
    logic    rdReqNext;
    logic    aluReqNext;
    regAddrT frameAddr;     // address byte of a write frame

    always_comb
    begin
        nextState  = state;
        wrEnNext   = 1'b0;
        rdReqNext  = 1'b0;
        aluReqNext = 1'b0;
        case (state)
            stIdle:
            begin
                if (rxDataValid)
                begin
                    case (rxData)
                        cmdRfWrite:       nextState = stWrAddr;
                        cmdRfRead:        nextState = stRdAddr;
                        cmdAluOperands:   nextState = stOpA;
                        cmdAluNoOperands: nextState = stFun;    // skips operand bytes
                        default:          nextState = stIdle;   // junk byte dropped
                    endcase
                end
            end
            stWrAddr:
            begin
                if (rxDataValid)
                    nextState = stWrData;
            end
            stWrData:
            begin
                if (rxDataValid)
                begin
                    wrEnNext  = 1'b1;
                    nextState = stIdle;   // write frame complete
                end
            end
            stRdAddr:
            begin
                if (rxDataValid)
                begin
                    rdReqNext = 1'b1;
                    nextState = stWaitResult;
                end
            end
            stOpA:
            begin
                if (rxDataValid)
                begin
                    wrEnNext  = 1'b1;    // operand A into slot 0
                    nextState = stOpB;
                end
            end
            stOpB:
            begin
                if (rxDataValid)
                begin
                    wrEnNext  = 1'b1;    // operand B into slot 1
                    nextState = stFun;
                end
            end
            stFun:
            begin
                if (rxDataValid)
                begin
                    aluReqNext = 1'b1;
                    nextState  = stWaitResult;
                end
            end
            stWaitResult:
            begin
                if (sendDone)            // rx bytes ignored meanwhile
                    nextState = stIdle;
            end
            default: nextState = stIdle;
        endcase
    end

    always_ff @(posedge REF_CLK or negedge RST)
    begin
        if (!RST)
        begin
            state   <= stIdle;
            regWrEn <= 1'b0;
            rdReq   <= 1'b0;
            aluReq  <= 1'b0;
        end
        else
        begin
            state   <= nextState;
            regWrEn <= wrEnNext;     // single cycle strobe
            rdReq   <= rdReqNext;
            aluReq  <= aluReqNext;
        end
    end

    // payload capture held until the next frame overwrites it
    always_ff @(posedge REF_CLK)
    begin
        if (rxDataValid)
        begin
            case (state)
                stWrAddr: frameAddr <= rxData[addrW-1:0];
                stWrData:
                begin
                    regAddr   <= frameAddr;
                    regWrData <= rxData;
                end
                stRdAddr: regAddr <= rxData[addrW-1:0];  // held through the read
                stOpA:
                begin
                    regAddr   <= operandAAddr;
                    regWrData <= rxData;
                end
                stOpB:
                begin
                    regAddr   <= operandBAddr;
                    regWrData <= rxData;
                end
                stFun: aluFun <= rxData[aluFunW-1:0];   // low nibble only
                default: ;
            endcase
        end
    end

endmodule

//--- hdl/cmdExecute.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Runs one register read or ALU operation per request and
// passes the captured response on as a result word.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module cmdExecute
    import sysCtrlPkg::*;
(
    input  logic       REF_CLK,
    input  logic       RST,
    input  logic       rdReq,         // pulse from decoder
    input  logic       aluReq,        // pulse from decoder
    input  dataByteT   rdData,
    input  logic       rdDataValid,
    input  resultWordT aluOut,
    input  logic       aluOutValid,
    output logic       rdEn,
    output logic       aluEn,
    output logic       aluClkEn,
    output logic       resultValid,
    output resultWordT resultWord
);

    logic rdHit;    // read response seen
    logic aluHit;   // alu response seen

    // responses only count while their request is open
    assign rdHit  = rdEn && rdDataValid;
    assign aluHit = aluClkEn && aluOutValid;

    always_ff @(posedge REF_CLK or negedge RST)
    begin
        if (!RST)
        begin
            rdEn        <= 1'b0;
            aluEn       <= 1'b0;
            aluClkEn    <= 1'b0;
            resultValid <= 1'b0;
        end
        else
        begin
            aluEn       <= aluReq;            // one cycle start pulse
            resultValid <= rdHit || aluHit;
            if (rdReq)
                rdEn <= 1'b1;
            else if (rdHit)
                rdEn <= 1'b0;                 // latency is up to the rf
            if (aluReq)
                aluClkEn <= 1'b1;
            else if (aluHit)
                aluClkEn <= 1'b0;             // gate alu clock again
        end
    end

    always_ff @(posedge REF_CLK)
    begin
        if (rdHit)
            resultWord <= {{(resultW - dataW){1'b0}}, rdData};  // zero high byte
        else if (aluHit)
            resultWord <= aluOut;
    end

endmodule

//--- hdl/resultSender.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Serialises a result word to the UART transmitter, low byte
// first, high byte only when nonzero. Stalls on txBusy.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module resultSender
    import sysCtrlPkg::*;
(
    input  logic       REF_CLK,
    input  logic       RST,
    input  logic       resultValid,
    input  resultWordT resultWord,
    input  logic       txBusy,        // level from transmitter
    output dataByteT   txData,
    output logic       txDataValid,
    output logic       sendDone       // pulse after the last byte
);

    typedef enum logic [1:0]
    {
        stIdle,
        stLow,
        stGap,
        stHigh
    } stateT;

    stateT      state;
    resultWordT heldWord;
    logic       highNonZero;
    logic       sendSlot;   // state wants to send a byte

    assign highNonZero = heldWord[dataW +: dataW] != '0;
    assign sendSlot    = (state == stLow) || (state == stHigh);
    assign txDataValid = sendSlot && !txBusy;   // never while tx is busy
    assign txData      = (state == stHigh) ? heldWord[dataW +: dataW]
                                           : heldWord[dataW-1:0];

    always_ff @(posedge REF_CLK or negedge RST)
    begin
        if (!RST)
        begin
            state    <= stIdle;
            sendDone <= 1'b0;
        end
        else
        begin
            sendDone <= 1'b0;
            case (state)
                stIdle:
                begin
                    if (resultValid)
                        state <= stLow;
                end
                stLow:
                begin
                    if (!txBusy)
                    begin
                        if (highNonZero)
                            state <= stGap;   // let txBusy come up
                        else
                        begin
                            state    <= stIdle;
                            sendDone <= 1'b1;
                        end
                    end
                end
                stGap: state <= stHigh;
                stHigh:
                begin
                    if (!txBusy)
                    begin
                        state    <= stIdle;
                        sendDone <= 1'b1;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge REF_CLK)
    begin
        if (resultValid && (state == stIdle))
            heldWord <= resultWord;   // stable until both bytes left
    end

endmodule

//--- hdl/sysCtrlTop.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// System controller top. Chains decoder, execute and result
// sender between the UART, register file and ALU.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module sysCtrlTop
    import sysCtrlPkg::*;
(
    input  logic       REF_CLK,
    input  logic       RST,
    input  dataByteT   rxData,
    input  logic       rxDataValid,
    input  dataByteT   rdData,
    input  logic       rdDataValid,
    input  resultWordT aluOut,
    input  logic       aluOutValid,
    input  logic       txBusy,
    output regAddrT    regAddr,
    output dataByteT   regWrData,
    output logic       regWrEn,
    output logic       rdEn,
    output aluFunT     aluFun,
    output logic       aluEn,
    output logic       aluClkEn,
    output dataByteT   txData,
    output logic       txDataValid
);

    logic       rdReq;          // decoder to execute
    logic       aluReq;
    logic       resultValid;    // execute to sender
    resultWordT resultWord;
    logic       sendDone;       // sender back to decoder

    cmdDecoder cmdDecoder_i (
        .REF_CLK     (REF_CLK),
        .RST         (RST),
        .rxData      (rxData),
        .rxDataValid (rxDataValid),
        .sendDone    (sendDone),
        .regAddr     (regAddr),
        .regWrData   (regWrData),
        .regWrEn     (regWrEn),
        .aluFun      (aluFun),
        .rdReq       (rdReq),
        .aluReq      (aluReq)
    );

    cmdExecute cmdExecute_i (
        .REF_CLK     (REF_CLK),
        .RST         (RST),
        .rdReq       (rdReq),
        .aluReq      (aluReq),
        .rdData      (rdData),
        .rdDataValid (rdDataValid),
        .aluOut      (aluOut),
        .aluOutValid (aluOutValid),
        .rdEn        (rdEn),
        .aluEn       (aluEn),
        .aluClkEn    (aluClkEn),
        .resultValid (resultValid),
        .resultWord  (resultWord)
    );

    resultSender resultSender_i (
        .REF_CLK     (REF_CLK),
        .RST         (RST),
        .resultValid (resultValid),
        .resultWord  (resultWord),
        .txBusy      (txBusy),
        .txData      (txData),
        .txDataValid (txDataValid),
        .sendDone    (sendDone)
    );

endmodule

//--- verif/sysCtrl_assertions.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Protocol assertions on the controller outputs, bound into
// the top level.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module sysCtrlAssertions (
    input logic REF_CLK,
    input logic RST,
    input logic txDataValid,
    input logic txBusy,
    input logic regWrEn,
    input logic rdEn,
    input logic aluEn,
    input logic aluClkEn
);

    txNotBusy: assert property (@(posedge REF_CLK) disable iff (!RST)
        !(txDataValid && txBusy))
        else $error("txDataValid high while txBusy is high");

    wrOneCycle: assert property (@(posedge REF_CLK) disable iff (!RST)
        regWrEn |=> !regWrEn)
        else $error("regWrEn held for more than one cycle");

    rdWrApart: assert property (@(posedge REF_CLK) disable iff (!RST)
        !(rdEn && regWrEn))
        else $error("rdEn and regWrEn high together");

    aluEnGated: assert property (@(posedge REF_CLK) disable iff (!RST)
        aluEn |-> aluClkEn)
        else $error("aluEn high without aluClkEn");

endmodule

bind sysCtrlTop sysCtrlAssertions sysCtrlAssertions_i (
    .REF_CLK     (REF_CLK),
    .RST         (RST),
    .txDataValid (txDataValid),
    .txBusy      (txBusy),
    .regWrEn     (regWrEn),
    .rdEn        (rdEn),
    .aluEn       (aluEn),
    .aluClkEn    (aluClkEn)
);

//--- verif/sysCtrlTests.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed tests and compare tasks, included inside the
// testbench module so they see its signals and models.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef sysCtrlTestsSvh
`define sysCtrlTestsSvh

dataByteT expMem [16];     // shadow of written register data
regAddrT  writtenQ [$];    // addresses written so far
dataByteT lastOpA;         // operands left in slots 0 and 1
dataByteT lastOpB;

task automatic checkByte(input string testName, input dataByteT expVal,
                         input dataByteT actVal);
    checkCount++;
    if (actVal !== expVal)
    begin
        errCount++;
        $display("MISMATCH %s: expected %02h, actual %02h", testName, expVal, actVal);
    end
endtask

task automatic checkAddr(input string testName, input regAddrT expVal,
                         input regAddrT actVal);
    checkCount++;
    if (actVal !== expVal)
    begin
        errCount++;
        $display("MISMATCH %s: expected %01h, actual %01h", testName, expVal, actVal);
    end
endtask

task automatic checkWord(input string testName, input resultWordT expVal,
                         input resultWordT actVal);
    checkCount++;
    if (actVal !== expVal)
    begin
        errCount++;
        $display("MISMATCH %s: expected %04h, actual %04h", testName, expVal, actVal);
    end
endtask

// strobes for one cycle and returns on the next falling edge
task automatic sendByte(input dataByteT b);
    @(negedge REF_CLK);
    rxData      = b;
    rxDataValid = 1'b1;
    @(negedge REF_CLK);
    rxDataValid = 1'b0;
endtask

// waits for n tx bytes and idles long enough to catch an extra one
task automatic waitBytes(input int n, input string testName);
    int cycles;
    cycles = 0;
    while ((sentQ.size() < n) && (cycles < 200))
    begin
        @(negedge REF_CLK);
        cycles++;
    end
    repeat (txHold + 4) @(negedge REF_CLK);
    checkCount++;
    if (sentQ.size() != n)
    begin
        errCount++;
        $display("ERROR: %s sent %0d bytes where %0d were expected",
                 testName, sentQ.size(), n);
    end
endtask

task automatic checkResult(input string testName, input resultWordT expWord);
    int         n;
    resultWordT got;
    n = (expWord[resultW-1:dataW] != '0) ? 2 : 1;   // high byte only when nonzero
    waitBytes(n, testName);
    checkByte({testName, " clkEn"}, 8'h00, {7'b0, aluClkEn});   // gated again after the answer
    if (sentQ.size() == n)
    begin
        got = (n == 2) ? {sentQ[1], sentQ[0]} : resultWordT'(sentQ[0]);
        checkWord(testName, expWord, got);
    end
endtask

task automatic writeFrame(input string testName, input regAddrT addr, input dataByteT data);
    sendByte(cmdRfWrite);
    sendByte({4'h0, addr});
    sendByte(data);
    checkByte({testName, " strobe"}, 8'h01, {7'b0, regWrEn});
    checkAddr({testName, " addr"}, addr, regAddr);
    checkByte({testName, " data"}, data, regWrData);
    expMem[addr] = data;
    writtenQ.push_back(addr);
endtask

task automatic testReset();
    repeat (3) @(negedge REF_CLK);
    checkByte("reset controls", 8'h00, {3'b0, regWrEn, rdEn, aluEn, aluClkEn, txDataValid});
    checkCount++;
    if (sentQ.size() != 0)
    begin
        errCount++;
        $display("ERROR: reset: a byte was sent while no frame had arrived");
    end
endtask

task automatic testRfWrite();
    int wrBefore;
    int i;
    wrBefore = wrCount;
    sendByte(8'h55);          // unknown commands dropped in idle
    sendByte(8'h07);
    for (i = 0; i < 6; i++)
        writeFrame("rfWrite", regAddrT'($urandom_range(2, 15)), dataByteT'($urandom));
    repeat (2) @(negedge REF_CLK);
    checkCount++;
    if (wrCount - wrBefore != 6)
    begin
        errCount++;
        $display("ERROR: rfWrite: register file saw %0d writes for 6 frames",
                 wrCount - wrBefore);
    end
endtask

task automatic testRfRead();
    regAddrT addr;
    int      k;
    for (k = 0; k < 3; k++)
    begin
        addr      = writtenQ[$urandom_range(0, writtenQ.size() - 1)];
        rdLatency = $urandom_range(1, 4);
        sentQ.delete();
        sendByte(cmdRfRead);
        sendByte({4'h0, addr});
        checkAddr("rfRead addr", addr, regAddr);
        waitBytes(1, "rfRead");
        if (sentQ.size() == 1)
            checkByte("rfRead data", expMem[addr], sentQ[0]);
    end
    writeFrame("rfRead next frame", 4'hF, dataByteT'($urandom));   // accepted after read
endtask

task automatic testAluOperands();
    int funs [5] = '{0, 1, 2, 3, 7};
    int i;
    lastOpA = dataByteT'($urandom_range(16, 255));   // product always above 255
    lastOpB = dataByteT'($urandom_range(16, 255));
    for (i = 0; i < 5; i++)
    begin
        sentQ.delete();
        sendByte(cmdAluOperands);
        sendByte(lastOpA);
        checkAddr("aluOperands opA addr", operandAAddr, regAddr);
        checkByte("aluOperands opA data", lastOpA, regWrData);
        sendByte(lastOpB);
        checkAddr("aluOperands opB addr", operandBAddr, regAddr);
        checkByte("aluOperands opB data", lastOpB, regWrData);
        sendByte({4'h5, aluFunT'(funs[i])});   // high nibble must be ignored
        checkResult($sformatf("aluOperands fun %0d", funs[i]),
                    aluRule(aluFunT'(funs[i]), lastOpA, lastOpB));
    end
endtask

task automatic testAluNoOperands();
    int funs [3] = '{2, 1, 0};
    int i;
    txHold = 12;               // long back-pressure
    for (i = 0; i < 3; i++)
    begin
        sentQ.delete();
        sendByte(cmdAluNoOperands);
        sendByte({4'hA, aluFunT'(funs[i])});
        checkResult($sformatf("aluNoOperands fun %0d", funs[i]),
                    aluRule(aluFunT'(funs[i]), lastOpA, lastOpB));
    end
    txHold = 1;
endtask

`endif

//--- verif/sysCtrlTb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench top for the system controller. Models the register
// file, ALU and UART transmitter around the DUT, runs the
// directed tests and prints the summary.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module sysCtrlTb
    import sysCtrlPkg::*;
();

    localparam int numTests = 5;
    localparam int testSpan = 2000;          // watchdog budget per test
    localparam int rngSeed  = 32'hcfed_fd3a;

    logic       REF_CLK;
    logic       RST;
    dataByteT   rxData;
    logic       rxDataValid;
    dataByteT   rdData;
    logic       rdDataValid;
    resultWordT aluOut;
    logic       aluOutValid;
    logic       txBusy;
    regAddrT    regAddr;
    dataByteT   regWrData;
    logic       regWrEn;
    logic       rdEn;
    aluFunT     aluFun;
    logic       aluEn;
    logic       aluClkEn;
    dataByteT   txData;
    logic       txDataValid;

    dataByteT rfMem [16];     // register file model storage
    int       wrCount = 0;    // writes seen by the rf model
    int       rdLatency;      // rf answer delay set per read
    int       txHold;         // busy cycles after each tx byte
    dataByteT sentQ [$];      // bytes taken by the tx model
    int       errCount = 0;
    int       checkCount = 0;
    int       seedDummy;

    initial
    begin
        REF_CLK = 1'b0;
        forever #5 REF_CLK = ~REF_CLK;
    end

    sysCtrlTop sysCtrlTop_i (
        .REF_CLK     (REF_CLK),
        .RST         (RST),
        .rxData      (rxData),
        .rxDataValid (rxDataValid),
        .rdData      (rdData),
        .rdDataValid (rdDataValid),
        .aluOut      (aluOut),
        .aluOutValid (aluOutValid),
        .txBusy      (txBusy),
        .regAddr     (regAddr),
        .regWrData   (regWrData),
        .regWrEn     (regWrEn),
        .rdEn        (rdEn),
        .aluFun      (aluFun),
        .aluEn       (aluEn),
        .aluClkEn    (aluClkEn),
        .txData      (txData),
        .txDataValid (txDataValid)
    );

    // alu reference per function code
    function automatic resultWordT aluRule(input aluFunT fun, input dataByteT a,
                                           input dataByteT b);
        case (fun)
            4'd0:    return resultWordT'(a) + resultWordT'(b);
            4'd1:    return resultWordT'(a) - resultWordT'(b);   // wraps below zero
            4'd2:    return resultWordT'(a) * resultWordT'(b);
            4'd3:    return resultWordT'(a & b);
            default: return '0;
        endcase
    endfunction

    always @(posedge REF_CLK)
    begin
        if (regWrEn)
        begin
            rfMem[regAddr] <= regWrData;
            wrCount        <= wrCount + 1;
        end
    end

    initial
    begin
        rdData      = '0;
        rdDataValid = 1'b0;
        forever
        begin
            @(negedge REF_CLK);
            if (rdEn)
            begin
                repeat (rdLatency - 1) @(negedge REF_CLK);   // 1 to 4 cycles
                rdData      = rfMem[regAddr];
                rdDataValid = 1'b1;
                @(negedge REF_CLK);
                rdDataValid = 1'b0;
            end
        end
    end

    initial
    begin
        aluOut      = '0;
        aluOutValid = 1'b0;
        forever
        begin
            @(negedge REF_CLK);
            if (aluEn)
            begin
                @(negedge REF_CLK);   // answer two cycles after aluEn
                aluOut      = aluRule(aluFun, rfMem[operandAAddr], rfMem[operandBAddr]);
                aluOutValid = 1'b1;
                @(negedge REF_CLK);
                aluOutValid = 1'b0;
            end
        end
    end

    initial
    begin
        txBusy = 1'b0;
        forever
        begin
            @(posedge REF_CLK);
            if (txDataValid)
            begin
                sentQ.push_back(txData);   // byte taken on this edge
                if (txHold > 0)
                begin
                    @(negedge REF_CLK);
                    txBusy = 1'b1;
                    repeat (txHold) @(negedge REF_CLK);
                    txBusy = 1'b0;
                end
            end
        end
    end

    `include "sysCtrlTests.svh"

    initial
    begin
        #(numTests * testSpan);
        $display("ERROR: watchdog expired before the tests finished");
        $display("Some tests failed");
        $finish;
    end

    initial
    begin
        seedDummy   = $urandom(rngSeed);
        RST         = 1'b0;
        rxData      = '0;
        rxDataValid = 1'b0;
        rdLatency   = 1;
        txHold      = 1;
        repeat (2) @(negedge REF_CLK);
        RST = 1'b1;
        testReset();
        testRfWrite();
        testRfRead();
        testAluOperands();
        testAluNoOperands();
        $display("Summary: %0d checks, %0d errors", checkCount, errCount);
        if (errCount == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

//--- build.f
+incdir+verif
hdl/sysCtrlPkg.sv
hdl/cmdDecoder.sv
hdl/cmdExecute.sv
hdl/resultSender.sv
hdl/sysCtrlTop.sv
verif/sysCtrl_assertions.sv
verif/sysCtrlTb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile and run the system controller testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert --top-module sysCtrlTb -f build.f -o sysCtrlSim
if [ $? -ne 0 ]; then
    echo "verilator compile step failed"
    exit 1
fi

./obj_dir/sysCtrlSim > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "Some tests failed" "$logFile"; then
    exit 1
fi
exit 0
